// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ping-pong controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_pp_top -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_pp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation reported errors"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== sim/tb_pp_top.sv ====
////////////////////////////////////////
// Testbench for the ping-pong controller
// LFSR stimulus, cycle model, assertions
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_pp_top
    import pp_pkg::*;
();

    // Bank swaps to reach before the run ends
    localparam int PLANNED_FILLS = 8;
    // One fill plus a drain at the slowest acc_done rate, in cycles
    localparam int FILL_CYCLES   = 600;
    localparam int CLK_NS        = 100;
    localparam int WATCHDOG_NS   = PLANNED_FILLS * FILL_CYCLES * CLK_NS + 20 * CLK_NS;

    // Every output in one word
    // {strobes, bank 0 addresses, bank 1 addresses, slice_idx, write_bank, write_blocked}
    localparam int OUT_W = 8 * ADDR_W + SLICE_W + 8;
    // Only west B of bank 0 leaves reset nonzero
    localparam logic [OUT_W-1:0] RESET_WORD =
        {6'b0, ADDR_W'(0), ADDR_W'(FILL_ROWS), {(6 * ADDR_W){1'b0}}, SLICE_W'(0), 2'b0};

    logic clk;
    logic rst_n;
    logic in_valid;
    logic systolic_finish;
    logic acc_done;
    logic w_bank0_wea, w_bank0_web, w_bank1_wea, w_bank1_web;
    logic n_bank0_wea, n_bank1_wea;
    logic [ADDR_W-1:0] w_bank0_addra, w_bank0_addrb, w_bank1_addra, w_bank1_addrb;
    logic [ADDR_W-1:0] n_bank0_addra, n_bank0_addrb, n_bank1_addra, n_bank1_addrb;
    logic [SLICE_W-1:0] slice_idx;
    logic write_bank;
    logic write_blocked;
    logic [OUT_W-1:0] out_word;

    int mismatches   = 0;
    int other_errors = 0;
    logic [16:0] lfsr;

    // Reference model state
    int   m_slice;
    int   m_row;
    int   m_blk;
    int   m_col;
    logic m_bank;
    logic m_full;
    logic m_loaded;
    logic m_full_p;
    logic m_done_p;
    logic m_acc_q;
    // Issued one stage before the bank ports
    // Write word is {west A, west B, north A, 0}, read word is {west A, west B, 0, north B}
    logic                iss_we;
    logic [4*ADDR_W-1:0] iss_wr;
    logic [4*ADDR_W-1:0] iss_rd;
    // Expected bank ports, strobe and {west A, west B, north A, north B}
    logic                e_we   [2];
    logic [4*ADDR_W-1:0] e_addr [2];

    pp_top UUT (.*);

    assign out_word = {w_bank0_wea, w_bank0_web, n_bank0_wea,
                       w_bank1_wea, w_bank1_web, n_bank1_wea,
                       w_bank0_addra, w_bank0_addrb, n_bank0_addra, n_bank0_addrb,
                       w_bank1_addra, w_bank1_addrb, n_bank1_addra, n_bank1_addrb,
                       slice_idx, write_bank, write_blocked};

    always #50 clk = ~clk;

    // 17-bit Fibonacci LFSR, taps 17 and 14
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        mismatches++;
        $display("FAILED %s: got %0h expected %0h at %0t", name, got, want, $time);
    endtask

    always @(posedge clk) begin : model
        logic accepted;
        logic row_write;
        logic reading;
        logic acc_rise;
        if (!rst_n) begin
            m_slice   <= 0;
            m_row     <= 0;
            m_blk     <= 0;
            m_col     <= 0;
            m_bank    <= 1'b0;
            m_full    <= 1'b0;
            m_loaded  <= 1'b0;
            m_full_p  <= 1'b0;
            m_done_p  <= 1'b0;
            m_acc_q   <= 1'b0;
            iss_we    <= 1'b0;
            iss_wr    <= {ADDR_W'(0), ADDR_W'(FILL_ROWS), ADDR_W'(0), ADDR_W'(0)};
            iss_rd    <= '0;
            e_we[0]   <= 1'b0;
            e_we[1]   <= 1'b0;
            e_addr[0] <= {ADDR_W'(0), ADDR_W'(FILL_ROWS), ADDR_W'(0), ADDR_W'(0)};
            e_addr[1] <= '0;
        end else begin
            accepted  = in_valid && !(m_full && m_loaded);
            row_write = accepted && (m_slice == NUM_SLICES - 1);
            // Reader idles in the cycle its drain is reported
            reading   = m_loaded && !m_done_p;
            acc_rise  = acc_done && !m_acc_q;
            m_acc_q  <= acc_done;

            // Writer, one row per NUM_SLICES accepted pulses
            if (accepted) begin
                m_slice <= (m_slice + 1) % NUM_SLICES;
            end
            iss_we   <= row_write;
            m_full_p <= row_write && (m_row == FILL_ROWS - 1);
            if (row_write) begin
                iss_wr <= {ADDR_W'(m_row), ADDR_W'(FILL_ROWS + m_row),
                           ADDR_W'(m_row), ADDR_W'(0)};
                m_row  <= (m_row + 1) % FILL_ROWS;
            end

            // Swap once the fill is complete and the reader is drained
            if (m_full && !m_loaded) begin
                m_bank   <= !m_bank;
                m_loaded <= 1'b1;
                m_full   <= 1'b0;
            end else begin
                if (m_full_p) begin
                    m_full <= 1'b1;
                end
                if (m_done_p) begin
                    m_loaded <= 1'b0;
                end
            end

            // Reader
            m_done_p <= 1'b0;
            if (reading && systolic_finish) begin
                iss_rd <= {ADDR_W'(m_blk), ADDR_W'(m_blk + BLOCKS_PER_ROW), ADDR_W'(0),
                           ADDR_W'(m_blk + BLOCKS_PER_ROW * m_col)};
                m_blk  <= (m_blk + 1) % BLOCKS_PER_ROW;
            end
            if (reading && acc_rise) begin
                m_col <= (m_col + 1) % COL_Y;
                if (m_col == COL_Y - 1) begin
                    m_blk    <= 0;
                    m_done_p <= 1'b1;
                end
            end

            // Bank port stage, write bank takes the write side
            for (int b = 0; b < 2; b++) begin
                e_we[b]   <= (m_bank == 1'(b)) && iss_we;
                e_addr[b] <= (m_bank == 1'(b)) ? iss_wr : iss_rd;
            end
        end
    end

    a_slice: assert property (@(posedge clk) disable iff (!rst_n)
        slice_idx == SLICE_W'(m_slice))
        else report_mismatch("slice_idx", 32'($sampled(slice_idx)),
                             32'($sampled(SLICE_W'(m_slice))));

    a_write_bank: assert property (@(posedge clk) disable iff (!rst_n)
        write_bank == m_bank)
        else report_mismatch("write_bank", 32'($sampled(write_bank)), 32'($sampled(m_bank)));

    a_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        write_blocked == (m_full && m_loaded))
        else report_mismatch("write_blocked", 32'($sampled(write_blocked)),
                             32'($sampled(m_full && m_loaded)));

    a_bank0_we: assert property (@(posedge clk) disable iff (!rst_n)
        {w_bank0_wea, w_bank0_web, n_bank0_wea} == {3{e_we[0]}})
        else report_mismatch("w_bank0_wea/web n_bank0_wea",
            32'($sampled({w_bank0_wea, w_bank0_web, n_bank0_wea})), 32'($sampled({3{e_we[0]}})));

    a_bank1_we: assert property (@(posedge clk) disable iff (!rst_n)
        {w_bank1_wea, w_bank1_web, n_bank1_wea} == {3{e_we[1]}})
        else report_mismatch("w_bank1_wea/web n_bank1_wea",
            32'($sampled({w_bank1_wea, w_bank1_web, n_bank1_wea})), 32'($sampled({3{e_we[1]}})));

    a_bank0_addr: assert property (@(posedge clk) disable iff (!rst_n)
        {w_bank0_addra, w_bank0_addrb, n_bank0_addra, n_bank0_addrb} == e_addr[0])
        else report_mismatch("w_bank0_addra/addrb n_bank0_addra/addrb",
            32'($sampled({w_bank0_addra, w_bank0_addrb, n_bank0_addra, n_bank0_addrb})),
            32'($sampled(e_addr[0])));

    a_bank1_addr: assert property (@(posedge clk) disable iff (!rst_n)
        {w_bank1_addra, w_bank1_addrb, n_bank1_addra, n_bank1_addrb} == e_addr[1])
        else report_mismatch("w_bank1_addra/addrb n_bank1_addra/addrb",
            32'($sampled({w_bank1_addra, w_bank1_addrb, n_bank1_addra, n_bank1_addrb})),
            32'($sampled(e_addr[1])));

    a_reset_values: assert property (@(posedge clk) $rose(rst_n) |-> out_word == RESET_WORD)
        else report_mismatch("pp_top outputs after reset", 64'($sampled(out_word)),
                             64'(RESET_WORD));

    initial begin : stimulus
        logic last_bank;
        logic blocked_seen;
        int   swaps;
        lfsr            = 17'd99358;
        clk             = 1'b0;
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        systolic_finish = 1'b0;
        acc_done        = 1'b0;
        last_bank       = 1'b0;
        blocked_seen    = 1'b0;
        swaps           = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        while (swaps < PLANNED_FILLS) begin
            @(negedge clk);
            if (write_bank != last_bank) begin
                swaps++;
            end
            last_bank = write_bank;
            if (write_blocked) begin
                blocked_seen = 1'b1;
            end
            in_valid        = lfsr_bit();
            systolic_finish = (take_bits(2) == 3);
            // Odd fills meet a slow reader so the writer has to wait
            if (take_bits((swaps % 2 == 1) ? 5 : 2) == 0) begin
                acc_done = ~acc_done;
            end
        end
        in_valid        = 1'b0;
        systolic_finish = 1'b0;
        // Flush the two register stages to the bank ports
        repeat (4) @(negedge clk);
        if (!blocked_seen) begin
            other_errors++;
            $display("The writer was never blocked by a loaded read bank");
        end
        $display("Mismatches: %0d, other failures: %0d", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before %0d bank swaps", WATCHDOG_NS,
                 PLANNED_FILLS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/pp_pkg.sv
src/pp_ctrl.sv
src/pp_write_gen.sv
src/pp_read_gen.sv
src/pp_bank_ports.sv
src/pp_top.sv
sim/tb_pp_top.sv

// ==== src/pp_bank_ports.sv ====
////////////////////////////////////////
// Per-bank port registers
// Steers write or read side onto each bank
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pp_bank_ports
    import pp_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write_bank,
    input  logic              wr_strobe,
    input  logic [ADDR_W-1:0] wr_addr_a,
    input  logic [ADDR_W-1:0] wr_addr_b,
    input  logic [ADDR_W-1:0] wr_addr_n,
    input  logic [ADDR_W-1:0] rd_addr_a,
    input  logic [ADDR_W-1:0] rd_addr_b,
    input  logic [ADDR_W-1:0] rd_addr_n,
    output logic              w_bank0_wea,
    output logic              w_bank0_web,
    output logic              w_bank1_wea,
    output logic              w_bank1_web,
    output logic              n_bank0_wea,
    output logic              n_bank1_wea,
    output logic [ADDR_W-1:0] w_bank0_addra,
    output logic [ADDR_W-1:0] w_bank0_addrb,
    output logic [ADDR_W-1:0] w_bank1_addra,
    output logic [ADDR_W-1:0] w_bank1_addrb,
    output logic [ADDR_W-1:0] n_bank0_addra,
    output logic [ADDR_W-1:0] n_bank0_addrb,
    output logic [ADDR_W-1:0] n_bank1_addra,
    output logic [ADDR_W-1:0] n_bank1_addrb
);

    // One strobe per bank, all three write ports fire on the same row
    logic              we_q    [2];
    logic [ADDR_W-1:0] w_a_q   [2];
    logic [ADDR_W-1:0] w_b_q   [2];
    logic [ADDR_W-1:0] n_a_q   [2];
    logic [ADDR_W-1:0] n_b_q   [2];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic is_wr;

        assign is_wr = (write_bank == 1'(b));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                we_q[b]  <= 1'b0;
                w_a_q[b] <= '0;
                // Bank 0 starts as the write bank, so its west B sits at the offset
                w_b_q[b] <= (b == 0) ? ADDR_W'(FILL_ROWS) : '0;
                n_a_q[b] <= '0;
                n_b_q[b] <= '0;
            end else if (is_wr) begin
                we_q[b]  <= wr_strobe;
                w_a_q[b] <= wr_addr_a;
                w_b_q[b] <= wr_addr_b;
                // North B is read-only, parked while writing
                n_a_q[b] <= wr_addr_n;
                n_b_q[b] <= '0;
            end else begin
                we_q[b]  <= 1'b0;
                w_a_q[b] <= rd_addr_a;
                w_b_q[b] <= rd_addr_b;
                // North A is write-only, parked while reading
                n_a_q[b] <= '0;
                n_b_q[b] <= rd_addr_n;
            end
        end
    end

    assign w_bank0_wea   = we_q[0];
    assign w_bank0_web   = we_q[0];
    assign n_bank0_wea   = we_q[0];
    assign w_bank1_wea   = we_q[1];
    assign w_bank1_web   = we_q[1];
    assign n_bank1_wea   = we_q[1];

    assign w_bank0_addra = w_a_q[0];
    assign w_bank0_addrb = w_b_q[0];
    assign n_bank0_addra = n_a_q[0];
    assign n_bank0_addrb = n_b_q[0];
    assign w_bank1_addra = w_a_q[1];
    assign w_bank1_addrb = w_b_q[1];
    assign n_bank1_addra = n_a_q[1];
    assign n_bank1_addrb = n_b_q[1];

    // Reader must never see its bank overwritten
    a_one_write_bank: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((w_bank0_wea | w_bank0_web | n_bank0_wea) &&
          (w_bank1_wea | w_bank1_web | n_bank1_wea))
    ) else $error("pp_bank_ports: write strobes on both banks");

endmodule

`default_nettype wire

// ==== src/pp_ctrl.sv ====
////////////////////////////////////////
// Bank-role control
// Full and loaded flags, swap decision
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pp_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_full,
    input  logic rd_done,
    output logic write_bank,
    output logic rd_active,
    output logic write_blocked
);

    // Write bank holds a complete fill
    logic bank_full;

    // Roles may exchange once the writer is done and the reader is idle
    logic swap;

    assign swap = bank_full & ~rd_active;

    // Writer waits only while the reader still owns the other bank
    assign write_blocked = bank_full & rd_active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Bank 0 is written first, bank 1 has nothing to read
            write_bank <= 1'b0;
            bank_full  <= 1'b0;
            rd_active  <= 1'b0;
        end else begin
            if (swap) begin
                // Freshly filled bank becomes the read bank
                write_bank <= ~write_bank;
                rd_active  <= 1'b1;
                bank_full  <= 1'b0;
            end else begin
                // Last row of the fill just went out
                if (wr_full) begin
                    bank_full <= 1'b1;
                end
                // Last output column consumed the read bank
                if (rd_done) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    // A second fill cannot finish while the first still waits for the reader
    a_no_refill: assert property (
        @(posedge clk) disable iff (!rst_n)
        bank_full |-> !wr_full
    ) else $error("pp_ctrl: wr_full while the write bank is already full");

    // Drain completion only comes from a bank that was loaded
    a_done_when_loaded: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_done |-> rd_active
    ) else $error("pp_ctrl: rd_done without a loaded read bank");

endmodule

`default_nettype wire

// ==== src/pp_pkg.sv ====
////////////////////////////////////////
// Buffer geometry shared by the ping-pong controller
// Derived counter and address widths
////////////////////////////////////////

`default_nettype none

package pp_pkg;

    // Write side
    // In_valid pulses that assemble one buffer row
    localparam int NUM_SLICES = 4;

    // Slice index width, kept at least one bit
    localparam int SLICE_W = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    // Rows written per bank fill
    // West port B writes the second half, starting at this offset
    localparam int FILL_ROWS = 4;

    // Single fill counter for west and north, so both depths are equal
    localparam int FILL_W = (FILL_ROWS > 1) ? $clog2(FILL_ROWS) : 1;

    // Read side
    // Inner dimension over block size
    // Also the stride between west A and west B, and between north columns
    localparam int BLOCKS_PER_ROW = 4;

    // Block counter width
    localparam int BLK_W = (BLOCKS_PER_ROW > 1) ? $clog2(BLOCKS_PER_ROW) : 1;

    // Output columns of matrix C produced from one loaded bank
    localparam int COL_Y = 2;

    // Column counter width
    localparam int COL_W = (COL_Y > 1) ? $clog2(COL_Y) : 1;

    // Buffer address width, same on every port of both banks
    // West B write tops out at 2*FILL_ROWS-1
    // North B read tops out at BLOCKS_PER_ROW*COL_Y-1
    localparam int ADDR_W = 4;

endpackage

`default_nettype wire

// ==== src/pp_read_gen.sv ====
////////////////////////////////////////
// Read address generator
// Block and column counters, acc_done edges
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pp_read_gen
    import pp_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              systolic_finish,
    input  logic              acc_done,
    input  logic              rd_active,
    output logic [ADDR_W-1:0] rd_addr_a,
    output logic [ADDR_W-1:0] rd_addr_b,
    output logic [ADDR_W-1:0] rd_addr_n,
    output logic              rd_done
);

    // Block within the inner dimension
    logic [BLK_W-1:0] blk_cnt;

    // Output column of matrix C
    logic [COL_W-1:0] col_cnt;

    // Previous acc_done level for edge detection
    logic acc_done_d;

    logic acc_rise;
    logic reading;
    logic last_blk;
    logic last_col;

    assign acc_rise = acc_done & ~acc_done_d;
    assign last_blk = (blk_cnt == BLK_W'(BLOCKS_PER_ROW - 1));
    assign last_col = (col_cnt == COL_W'(COL_Y - 1));

    // The done pulse is still in flight to the control for one cycle
    // Hold off any access to the drained bank during it
    assign reading = rd_active & ~rd_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_done_d <= 1'b0;
            blk_cnt    <= '0;
            col_cnt    <= '0;
            rd_done    <= 1'b0;
            rd_addr_a  <= '0;
            rd_addr_b  <= '0;
            rd_addr_n  <= '0;
        end else begin
            acc_done_d <= acc_done;
            rd_done    <= 1'b0;

            if (reading && systolic_finish) begin
                // West A and B read the two halves of the row
                rd_addr_a <= ADDR_W'(blk_cnt);
                rd_addr_b <= ADDR_W'(blk_cnt) + ADDR_W'(BLOCKS_PER_ROW);
                // North steps one full block row per output column
                rd_addr_n <= ADDR_W'(blk_cnt) + ADDR_W'(BLOCKS_PER_ROW * col_cnt);
                blk_cnt   <= last_blk ? '0 : blk_cnt + 1'b1;
            end

            if (reading && acc_rise) begin
                if (last_col) begin
                    // Drain complete, next bank starts from block 0 column 0
                    col_cnt <= '0;
                    blk_cnt <= '0;
                    rd_done <= 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/pp_top.sv ====
////////////////////////////////////////
// Ping-pong buffer controller top level
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pp_top
    import pp_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               systolic_finish,
    input  logic               acc_done,
    output logic               w_bank0_wea,
    output logic               w_bank0_web,
    output logic               w_bank1_wea,
    output logic               w_bank1_web,
    output logic               n_bank0_wea,
    output logic               n_bank1_wea,
    output logic [ADDR_W-1:0]  w_bank0_addra,
    output logic [ADDR_W-1:0]  w_bank0_addrb,
    output logic [ADDR_W-1:0]  w_bank1_addra,
    output logic [ADDR_W-1:0]  w_bank1_addrb,
    output logic [ADDR_W-1:0]  n_bank0_addra,
    output logic [ADDR_W-1:0]  n_bank0_addrb,
    output logic [ADDR_W-1:0]  n_bank1_addra,
    output logic [ADDR_W-1:0]  n_bank1_addrb,
    output logic [SLICE_W-1:0] slice_idx,
    output logic               write_bank,
    output logic               write_blocked
);

    // Control handshakes
    logic rd_active;
    logic wr_full;
    logic rd_done;

    // Write side, one cycle ahead of the bank ports
    logic              wr_strobe;
    logic [ADDR_W-1:0] wr_addr_a;
    logic [ADDR_W-1:0] wr_addr_b;
    logic [ADDR_W-1:0] wr_addr_n;

    // Read side, one cycle ahead of the bank ports
    logic [ADDR_W-1:0] rd_addr_a;
    logic [ADDR_W-1:0] rd_addr_b;
    logic [ADDR_W-1:0] rd_addr_n;

    pp_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_full       (wr_full),
        .rd_done       (rd_done),
        .write_bank    (write_bank),
        .rd_active     (rd_active),
        .write_blocked (write_blocked)
    );

    pp_write_gen u_write_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .write_blocked (write_blocked),
        .slice_idx     (slice_idx),
        .wr_strobe     (wr_strobe),
        .wr_full       (wr_full),
        .wr_addr_a     (wr_addr_a),
        .wr_addr_b     (wr_addr_b),
        .wr_addr_n     (wr_addr_n)
    );

    pp_read_gen u_read_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .rd_active       (rd_active),
        .rd_addr_a       (rd_addr_a),
        .rd_addr_b       (rd_addr_b),
        .rd_addr_n       (rd_addr_n),
        .rd_done         (rd_done)
    );

    pp_bank_ports u_bank_ports (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_bank    (write_bank),
        .wr_strobe     (wr_strobe),
        .wr_addr_a     (wr_addr_a),
        .wr_addr_b     (wr_addr_b),
        .wr_addr_n     (wr_addr_n),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_addr_n     (rd_addr_n),
        .w_bank0_wea   (w_bank0_wea),
        .w_bank0_web   (w_bank0_web),
        .w_bank1_wea   (w_bank1_wea),
        .w_bank1_web   (w_bank1_web),
        .n_bank0_wea   (n_bank0_wea),
        .n_bank1_wea   (n_bank1_wea),
        .w_bank0_addra (w_bank0_addra),
        .w_bank0_addrb (w_bank0_addrb),
        .w_bank1_addra (w_bank1_addra),
        .w_bank1_addrb (w_bank1_addrb),
        .n_bank0_addra (n_bank0_addra),
        .n_bank0_addrb (n_bank0_addrb),
        .n_bank1_addra (n_bank1_addra),
        .n_bank1_addrb (n_bank1_addrb)
    );

endmodule

`default_nettype wire

// ==== src/pp_write_gen.sv ====
////////////////////////////////////////
// Write address generator
// Slice index, fill counter, row strobes
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pp_write_gen
    import pp_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              write_blocked,
    output logic [SLICE_W-1:0] slice_idx,
    output logic              wr_strobe,
    output logic              wr_full,
    output logic [ADDR_W-1:0] wr_addr_a,
    output logic [ADDR_W-1:0] wr_addr_b,
    output logic [ADDR_W-1:0] wr_addr_n
);

    // Row being written in the current fill
    logic [FILL_W-1:0] fill_cnt;

    logic accept;
    logic last_slice;
    logic last_row;
    logic row_write;

    // in_valid is dropped, not queued, while blocked
    assign accept     = in_valid & ~write_blocked;
    assign last_slice = (slice_idx == SLICE_W'(NUM_SLICES - 1));
    assign last_row   = (fill_cnt == FILL_W'(FILL_ROWS - 1));
    assign row_write  = accept & last_slice;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slice_idx <= '0;
            fill_cnt  <= '0;
            wr_strobe <= 1'b0;
            wr_full   <= 1'b0;
            wr_addr_a <= '0;
            wr_addr_b <= ADDR_W'(FILL_ROWS);
            wr_addr_n <= '0;
        end else begin
            // One-cycle pulses by default
            wr_strobe <= row_write;
            wr_full   <= row_write & last_row;

            if (accept) begin
                slice_idx <= last_slice ? '0 : slice_idx + 1'b1;
            end

            if (row_write) begin
                // West A and north A share the row, west B sits one fill higher
                wr_addr_a <= ADDR_W'(fill_cnt);
                wr_addr_b <= ADDR_W'(FILL_ROWS) + ADDR_W'(fill_cnt);
                wr_addr_n <= ADDR_W'(fill_cnt);
                fill_cnt  <= last_row ? '0 : fill_cnt + 1'b1;
            end
        end
    end

    // Blocking on one edge suppresses the strobe produced by that edge
    a_blocked_no_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(write_blocked) |-> !wr_strobe
    ) else $error("pp_write_gen: row strobe while the writer was blocked");

endmodule

`default_nettype wire
